// ==== cache_types.sv ====
package cache_types;

    localparam int WAYS          = 4;
    localparam int LINE_BITS     = 256;
    localparam int SET_BITS      = 4;
    localparam int NUM_SETS      = 16;
    localparam int OFFSET_BITS   = 5;
    localparam int TAG_BITS      = 23;
    // Dirty bit sits above the tag
    localparam int TAG_WORD_BITS = 24;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set;
        logic [2:0]          word;
        logic [1:0]          byte_ofs;
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } cache_addr_t;

    typedef struct packed {
        cache_addr_t addr;
        logic        rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0]          addr;
        logic                 read;
        logic                 write;
        logic [LINE_BITS-1:0] wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        idle_s,
        compare_tag_s,
        writeback_s,
        allocate_s,
        refill_s
    } state_t;

endpackage

// ==== ff_array.sv ====
`timescale 1ns/1ps

module ff_array #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Registered read returns the old entry on a same-cycle write
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
            dout <= '0;
        end else begin
            if (we) begin
                mem[addr] <= din;
            end
            dout <= mem[addr];
        end
    end

endmodule

// ==== sram_array.sv ====
`timescale 1ns/1ps

module sram_array #(
    parameter int WIDTH     = 256,
    parameter int DEPTH     = 16,
    parameter int MASK_BITS = 32
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [MASK_BITS-1:0]     wmask,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    localparam int GRAN = WIDTH / MASK_BITS;

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            // Only granules with their mask bit set change
            for (int g = 0; g < MASK_BITS; g++) begin
                if (wmask[g]) begin
                    mem[addr][g*GRAN +: GRAN] <= din[g*GRAN +: GRAN];
                end
            end
        end
        dout <= mem[addr];
    end

endmodule

// ==== control.sv ====
`timescale 1ns/1ps

module control (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_active,
    input  logic                hit,
    input  logic                dirty_victim,
    input  logic                dfp_resp,
    output cache_types::state_t state
);

    cache_types::state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_types::idle_s;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            cache_types::idle_s: begin
                // Arrays are read at the request set on this edge
                if (req_active) begin
                    next_state = cache_types::compare_tag_s;
                end
            end
            cache_types::compare_tag_s: begin
                if (hit) begin
                    next_state = cache_types::idle_s;
                end else if (dirty_victim) begin
                    next_state = cache_types::writeback_s;
                end else begin
                    next_state = cache_types::allocate_s;
                end
            end
            cache_types::writeback_s: begin
                if (dfp_resp) begin
                    next_state = cache_types::allocate_s;
                end
            end
            cache_types::allocate_s: begin
                if (dfp_resp) begin
                    next_state = cache_types::refill_s;
                end
            end
            cache_types::refill_s: begin
                // One cycle for the arrays to show the new line
                next_state = cache_types::compare_tag_s;
            end
            default: begin
                next_state = cache_types::idle_s;
            end
        endcase
    end

endmodule

// ==== cache_logic.sv ====
`timescale 1ns/1ps

module cache_logic (
    input  cache_types::state_t                                    state,
    input  cache_types::cpu_req_t                                  ufp_req,
    output logic [31:0]                                            ufp_rdata,
    output logic                                                   ufp_resp,
    output cache_types::mem_req_t                                  dfp_req,
    input  logic [cache_types::LINE_BITS-1:0]                      dfp_rdata,
    input  logic                                                   dfp_resp,
    output logic                                                   hit,
    output logic                                                   dirty_victim,
    input  logic [cache_types::WAYS-1:0]                           ways_valid,
    input  logic [cache_types::WAYS-1:0][cache_types::TAG_WORD_BITS-1:0] ways_tags,
    input  logic [cache_types::WAYS-1:0][cache_types::LINE_BITS-1:0]     ways_lines,
    input  logic [2:0]                                             plru_bits,
    output logic [2:0]                                             set_plru_bits,
    output logic                                                   plru_we,
    output logic [cache_types::WAYS-1:0]                           set_valid_we,
    output logic [cache_types::WAYS-1:0]                           set_tag_we,
    output logic [cache_types::TAG_WORD_BITS-1:0]                  set_tag,
    output logic [cache_types::WAYS-1:0]                           set_data_we,
    output logic [cache_types::LINE_BITS/8-1:0]                    data_mask,
    output logic [cache_types::LINE_BITS-1:0]                      set_line
);

    localparam int WAY_BITS   = $clog2(cache_types::WAYS);
    localparam int LINE_BYTES = cache_types::LINE_BITS / 8;
    localparam int LINE_WORDS = cache_types::LINE_BITS / 32;

    logic [cache_types::WAYS-1:0]     way_hit;
    logic [WAY_BITS-1:0]              hit_way;
    logic [WAY_BITS-1:0]              victim;
    logic [cache_types::TAG_BITS-1:0] req_tag;
    logic [cache_types::SET_BITS-1:0] req_set;
    logic [LINE_BYTES-1:0]            byte_mask;
    logic                             write_req;
    logic                             in_compare;

    assign req_tag    = ufp_req.addr.f.tag;
    assign req_set    = ufp_req.addr.f.set;
    assign write_req  = |ufp_req.wmask;
    assign in_compare = (state == cache_types::compare_tag_s);

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_types::WAYS; w++) begin
            way_hit[w] = ways_valid[w] &&
                         (ways_tags[w][cache_types::TAG_BITS-1:0] == req_tag);
            if (way_hit[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit = |way_hit;

    // Lowest invalid way wins over the tree
    always_comb begin
        if (plru_bits[0]) begin
            victim = plru_bits[2] ? 2'd3 : 2'd2;
        end else begin
            victim = plru_bits[1] ? 2'd1 : 2'd0;
        end
        for (int w = cache_types::WAYS - 1; w >= 0; w--) begin
            if (!ways_valid[w]) begin
                victim = WAY_BITS'(w);
            end
        end
    end

    assign dirty_victim = ways_valid[victim] &&
                          ways_tags[victim][cache_types::TAG_WORD_BITS-1];

    // Point the touched nodes away from the used way
    always_comb begin
        set_plru_bits = plru_bits;
        if (hit_way[1]) begin
            set_plru_bits[0] = 1'b0;
            set_plru_bits[2] = ~hit_way[0];
        end else begin
            set_plru_bits[0] = 1'b1;
            set_plru_bits[1] = ~hit_way[0];
        end
    end

    assign plru_we   = in_compare && hit;
    assign ufp_resp  = in_compare && hit;
    assign ufp_rdata = ways_lines[hit_way][{ufp_req.addr.f.word, 5'b0} +: 32];

    assign byte_mask = {{(LINE_BYTES-4){1'b0}}, ufp_req.wmask} << {ufp_req.addr.f.word, 2'b00};

    always_comb begin
        dfp_req.read  = (state == cache_types::allocate_s);
        dfp_req.write = (state == cache_types::writeback_s);
        dfp_req.wdata = ways_lines[victim];
        if (state == cache_types::writeback_s) begin
            // Old line address of the victim
            dfp_req.addr = {ways_tags[victim][cache_types::TAG_BITS-1:0], req_set,
                            {cache_types::OFFSET_BITS{1'b0}}};
        end else begin
            dfp_req.addr = {req_tag, req_set, {cache_types::OFFSET_BITS{1'b0}}};
        end
    end

    always_comb begin
        set_valid_we = '0;
        set_tag_we   = '0;
        set_data_we  = '0;
        set_tag      = {1'b1, req_tag};
        set_line     = {LINE_WORDS{ufp_req.wdata}};
        data_mask    = byte_mask;
        if (in_compare && hit && write_req) begin
            // Byte mask does the merge inside the data array
            set_tag_we[hit_way]  = 1'b1;
            set_data_we[hit_way] = 1'b1;
        end else if (state == cache_types::allocate_s && dfp_resp) begin
            set_tag              = {1'b0, req_tag};
            set_line             = dfp_rdata;
            data_mask            = '1;
            set_valid_we[victim] = 1'b1;
            set_tag_we[victim]   = 1'b1;
            set_data_we[victim]  = 1'b1;
        end
    end

endmodule

// ==== cache.sv ====
`timescale 1ns/1ps

module cache (
    input  logic                              clk,
    input  logic                              reset,
    input  cache_types::cpu_req_t             ufp_req,
    output logic [31:0]                       ufp_rdata,
    output logic                              ufp_resp,
    output cache_types::mem_req_t             dfp_req,
    input  logic [cache_types::LINE_BITS-1:0] dfp_rdata,
    input  logic                              dfp_resp
);

    localparam int WAYS       = cache_types::WAYS;
    localparam int LINE_BITS  = cache_types::LINE_BITS;
    localparam int TWORD_BITS = cache_types::TAG_WORD_BITS;

    cache_types::state_t state;

    logic                                 req_active;
    logic                                 hit;
    logic                                 dirty_victim;
    logic                                 plru_we;
    logic [2:0]                           plru_bits;
    logic [2:0]                           set_plru_bits;
    logic [WAYS-1:0]                      ways_valid;
    logic [WAYS-1:0][TWORD_BITS-1:0]      ways_tags;
    logic [WAYS-1:0][LINE_BITS-1:0]       ways_lines;
    logic [WAYS-1:0]                      set_valid_we;
    logic [WAYS-1:0]                      set_tag_we;
    logic [WAYS-1:0]                      set_data_we;
    logic [TWORD_BITS-1:0]                set_tag;
    logic [LINE_BITS/8-1:0]               data_mask;
    logic [LINE_BITS-1:0]                 set_line;
    logic [cache_types::SET_BITS-1:0]     index;

    // CPU holds the request, so the index is stable for the whole access
    assign index      = ufp_req.addr.f.set;
    assign req_active = ufp_req.rmask | (|ufp_req.wmask);

    control control_i (
        .clk          (clk),
        .reset        (reset),
        .req_active   (req_active),
        .hit          (hit),
        .dirty_victim (dirty_victim),
        .dfp_resp     (dfp_resp),
        .state        (state)
    );

    cache_logic cache_logic_i (
        .state         (state),
        .ufp_req       (ufp_req),
        .ufp_rdata     (ufp_rdata),
        .ufp_resp      (ufp_resp),
        .dfp_req       (dfp_req),
        .dfp_rdata     (dfp_rdata),
        .dfp_resp      (dfp_resp),
        .hit           (hit),
        .dirty_victim  (dirty_victim),
        .ways_valid    (ways_valid),
        .ways_tags     (ways_tags),
        .ways_lines    (ways_lines),
        .plru_bits     (plru_bits),
        .set_plru_bits (set_plru_bits),
        .plru_we       (plru_we),
        .set_valid_we  (set_valid_we),
        .set_tag_we    (set_tag_we),
        .set_tag       (set_tag),
        .set_data_we   (set_data_we),
        .data_mask     (data_mask),
        .set_line      (set_line)
    );

    ff_array #(.WIDTH(3), .DEPTH(cache_types::NUM_SETS)) plru_array (
        .clk   (clk),
        .reset (reset),
        .we    (plru_we),
        .addr  (index),
        .din   (set_plru_bits),
        .dout  (plru_bits)
    );

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        ff_array #(.WIDTH(1), .DEPTH(cache_types::NUM_SETS)) valid_array (
            .clk   (clk),
            .reset (reset),
            .we    (set_valid_we[w]),
            .addr  (index),
            .din   (1'b1),
            .dout  (ways_valid[w])
        );

        sram_array #(
            .WIDTH     (TWORD_BITS),
            .DEPTH     (cache_types::NUM_SETS),
            .MASK_BITS (1)
        ) tag_array (
            .clk   (clk),
            .we    (set_tag_we[w]),
            .wmask (1'b1),
            .addr  (index),
            .din   (set_tag),
            .dout  (ways_tags[w])
        );

        sram_array #(
            .WIDTH     (LINE_BITS),
            .DEPTH     (cache_types::NUM_SETS),
            .MASK_BITS (LINE_BITS/8)
        ) data_array (
            .clk   (clk),
            .we    (set_data_we[w]),
            .wmask (data_mask),
            .addr  (index),
            .din   (set_line),
            .dout  (ways_lines[w])
        );
    end

endmodule

// ==== mem_model.sv ====
`timescale 1ns/1ps

module mem_model (
    input  logic                              clk,
    input  logic                              reset,
    input  cache_types::mem_req_t             dfp_req,
    output logic [cache_types::LINE_BITS-1:0] dfp_rdata,
    output logic                              dfp_resp,
    output logic [31:0]                       read_count,
    output logic [31:0]                       write_count
);

    // Words that were never written follow the fill rule
    logic [31:0] store [logic [31:0]];
    logic [1:0]  delay_cnt;

    function automatic logic [31:0] load_word(input logic [31:0] addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr ^ 32'hd848a5a5;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            dfp_resp    <= 1'b0;
            delay_cnt   <= 2'd0;
            read_count  <= 32'd0;
            write_count <= 32'd0;
        end else begin
            dfp_resp <= 1'b0;
            // Skip the response cycle itself so one request counts once
            if ((dfp_req.read || dfp_req.write) && !dfp_resp) begin
                if (delay_cnt == 2'd2) begin
                    delay_cnt <= 2'd0;
                    dfp_resp  <= 1'b1;
                    for (int i = 0; i < 8; i++) begin
                        if (dfp_req.read) begin
                            dfp_rdata[32*i +: 32] <= load_word(dfp_req.addr + 32'(i * 4));
                        end else begin
                            store[dfp_req.addr + 32'(i * 4)] = dfp_req.wdata[32*i +: 32];
                        end
                    end
                    if (dfp_req.read) begin
                        read_count <= read_count + 32'd1;
                    end else begin
                        write_count <= write_count + 32'd1;
                    end
                end else begin
                    delay_cnt <= delay_cnt + 2'd1;
                end
            end
        end
    end

endmodule

// ==== cache_props.sv ====
`timescale 1ns/1ps

module cache_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  ufp_resp,
    input cache_types::mem_req_t dfp_req,
    input logic                  dfp_resp
);

    dfp_one_op: assert property (@(posedge clk) disable iff (reset)
        !(dfp_req.read && dfp_req.write))
        else $error("dfp read and write set in the same cycle");

    ufp_resp_pulse: assert property (@(posedge clk) disable iff (reset)
        ufp_resp |=> !ufp_resp)
        else $error("ufp_resp held for two cycles");

    // Request must not move before memory answers
    dfp_req_hold: assert property (@(posedge clk) disable iff (reset)
        ((dfp_req.read || dfp_req.write) && !dfp_resp) |=> $stable(dfp_req))
        else $error("dfp request changed before dfp_resp");

endmodule

bind cache cache_props cache_props_i (
    .clk      (clk),
    .reset    (reset),
    .ufp_resp (ufp_resp),
    .dfp_req  (dfp_req),
    .dfp_resp (dfp_resp)
);

// ==== cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb;

    logic                              clk;
    logic                              reset;
    cache_types::cpu_req_t             ufp_req;
    logic [31:0]                       ufp_rdata;
    logic                              ufp_resp;
    cache_types::mem_req_t             dfp_req;
    logic [cache_types::LINE_BITS-1:0] dfp_rdata;
    logic                              dfp_resp;
    logic [31:0]                       read_count;
    logic [31:0]                       write_count;

    logic [31:0]                       wb_addr;
    logic [cache_types::LINE_BITS-1:0] wb_line;
    logic [31:0]                       shadow [logic [31:0]];
    integer                            seed;
    int                                errors;
    int                                tests_run;
    int                                tests_failed;
    logic                              timed_out;

    cache cache_i (
        .clk       (clk),
        .reset     (reset),
        .ufp_req   (ufp_req),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_req   (dfp_req),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    mem_model mem_model_i (
        .clk         (clk),
        .reset       (reset),
        .dfp_req     (dfp_req),
        .dfp_rdata   (dfp_rdata),
        .dfp_resp    (dfp_resp),
        .read_count  (read_count),
        .write_count (write_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Last line written back to memory
    always @(negedge clk) begin
        if (dfp_resp && dfp_req.write) begin
            wb_addr = dfp_req.addr;
            wb_line = dfp_req.wdata;
        end
    end

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'hd848a5a5;
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input logic [3:0] wm,
                                input logic [31:0] wd);
        logic [31:0] word;
        word = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (wm[b]) begin
                word[8*b +: 8] = wd[8*b +: 8];
            end
        end
        shadow[{addr[31:2], 2'b00}] = word;
    endtask

    task automatic log_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // Latency counts edges after the first one that sees the request
    task automatic cpu_access(input logic [31:0] addr, input logic rd, input logic [3:0] wm,
                              input logic [31:0] wd, output logic [31:0] rdata,
                              output int latency);
        cache_types::cpu_req_t req;
        int                    waited;
        logic                  seen;
        req.addr.raw = addr;
        req.rmask    = rd;
        req.wmask    = wm;
        req.wdata    = wd;
        seen         = 1'b0;
        waited       = 0;
        rdata        = '0;
        latency      = -1;
        @(posedge clk);
        ufp_req <= req;
        while (!seen && waited < 200) begin
            @(negedge clk);
            waited++;
            if (ufp_resp) begin
                seen  = 1'b1;
                rdata = ufp_rdata;
            end
        end
        @(posedge clk);
        ufp_req <= '0;
        if (seen) begin
            latency = waited - 1;
            if (wm != 4'b0) begin
                shadow_write(addr, wm, wd);
            end
        end else begin
            $display("Timeout: no ufp_resp within 200 cycles for address %h", addr);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic read_expect(input logic [31:0] addr, output int latency);
        logic [31:0] got;
        logic [31:0] exp;
        exp = expected_word(addr);
        cpu_access(addr, 1'b1, 4'b0, 32'b0, got, latency);
        if (got !== exp) begin
            log_error($sformatf("read %h returned %h, expected %h", addr, got, exp));
        end
    endtask

    task automatic test_read_miss();
        int          errs;
        int          lat;
        logic [31:0] reads;
        errs  = errors;
        reads = read_count;
        read_expect(32'h0000_0424, lat);
        if (read_count !== reads + 32'd1) begin
            log_error($sformatf("cold read made %0d memory reads", read_count - reads));
        end
        finish_test("read miss", errs);
    endtask

    task automatic test_read_hit();
        int          errs;
        int          lat;
        logic [31:0] reads;
        errs  = errors;
        reads = read_count;
        read_expect(32'h0000_043c, lat);
        if (read_count !== reads) begin
            log_error("read hit went to memory");
        end
        if (lat != 1) begin
            log_error($sformatf("read hit latency %0d, expected 1", lat));
        end
        finish_test("read hit", errs);
    endtask

    task automatic test_byte_write();
        int          errs;
        int          lat;
        logic [31:0] got;
        logic [31:0] reads;
        logic [31:0] writes;
        errs   = errors;
        reads  = read_count;
        writes = write_count;
        cpu_access(32'h0000_0428, 1'b0, 4'b0110, 32'hcafe_f00d, got, lat);
        if (lat != 1) begin
            log_error($sformatf("write hit latency %0d, expected 1", lat));
        end
        read_expect(32'h0000_0428, lat);
        if (read_count !== reads || write_count !== writes) begin
            log_error("byte write hit caused memory traffic");
        end
        finish_test("byte write hit", errs);
    endtask

    task automatic test_eviction();
        int                                errs;
        int                                lat;
        int                                i;
        logic [31:0]                       got;
        logic [31:0]                       reads;
        logic [31:0]                       writes;
        logic [cache_types::LINE_BITS-1:0] exp_line;
        errs = errors;
        // Tags 1 to 5 in set 5 with A as tag 1
        read_expect(32'h0000_02a0, lat);
        cpu_access(32'h0000_02ac, 1'b0, 4'b1111, 32'h1234_5678, got, lat);
        read_expect(32'h0000_04a0, lat);
        read_expect(32'h0000_06a0, lat);
        read_expect(32'h0000_08a0, lat);
        read_expect(32'h0000_04a4, lat);
        read_expect(32'h0000_06a4, lat);
        read_expect(32'h0000_08a4, lat);
        for (i = 0; i < 8; i++) begin
            exp_line[32*i +: 32] = expected_word(32'h0000_02a0 + 32'(i * 4));
        end
        reads  = read_count;
        writes = write_count;
        read_expect(32'h0000_0aa0, lat);
        if (read_count !== reads + 32'd1) begin
            log_error($sformatf("read of line E made %0d memory reads", read_count - reads));
        end
        if (write_count !== writes + 32'd1) begin
            log_error($sformatf("%0d writebacks seen, expected 1", write_count - writes));
        end else begin
            if (wb_addr !== 32'h0000_02a0) begin
                log_error($sformatf("writeback address %h, expected 000002a0", wb_addr));
            end
            if (wb_line !== exp_line) begin
                log_error("writeback data does not match the dirty line");
            end
        end
        reads = read_count;
        read_expect(32'h0000_02ac, lat);
        if (read_count !== reads + 32'd1) begin
            log_error("read of evicted line did not miss");
        end
        finish_test("eviction and writeback", errs);
    endtask

    task automatic test_random_traffic();
        int          errs;
        int          n;
        int          lat;
        int unsigned rnd;
        int unsigned set_sel;
        int unsigned tag_sel;
        int unsigned word_sel;
        logic [31:0] addr;
        logic [3:0]  wm;
        logic [31:0] wd;
        logic [31:0] got;
        errs = errors;
        for (n = 0; n < 60; n++) begin
            rnd      = $unsigned($random(seed));
            set_sel  = 8 + rnd % 3;
            tag_sel  = 16 + (rnd >> 4) % 6;
            word_sel = (rnd >> 8) % 8;
            addr     = (tag_sel << 9) | (set_sel << 5) | (word_sel << 2);
            if (rnd[12]) begin
                wm = rnd[19:16];
                if (wm == 4'b0) begin
                    wm = 4'b1111;
                end
                wd = $random(seed);
                cpu_access(addr, 1'b0, wm, wd, got, lat);
            end else begin
                read_expect(addr, lat);
            end
        end
        finish_test("random traffic", errs);
    endtask

    initial begin
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        seed         = 32'hd848;
        reset   <= 1'b1;
        ufp_req <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_read_miss();
        if (!timed_out) test_read_hit();
        if (!timed_out) test_byte_write();
        if (!timed_out) test_eviction();
        if (!timed_out) test_random_traffic();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
cache_types.sv
ff_array.sv
sram_array.sv
control.sv
cache_logic.sv
cache.sv
mem_model.sv
cache_props.sv
cache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module cache_tb -f all.f -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1 \
    || echo "simulation build or run did not complete" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0
